// File: design/io_fabric_cfg.svh
`ifndef IO_FABRIC_CFG_SVH
`define IO_FABRIC_CFG_SVH

// port bases; each IO_MW_* is the number of low address bits ignored on match
`define IO_MW_EXACT        0

`define IO_BASE_IDE0       16'h01F0
`define IO_MW_IDE0         3
`define IO_BASE_IDE0_ALT   16'h03F6
`define IO_BASE_IDE1       16'h0170
`define IO_MW_IDE1         3
`define IO_BASE_IDE1_ALT   16'h0376

`define IO_BASE_JOY        16'h0201

`define IO_BASE_FDD_A      16'h03F0
`define IO_MW_FDD_A        2
`define IO_BASE_FDD_B      16'h03F4
`define IO_MW_FDD_B        1
`define IO_BASE_FDD_C      16'h03F7

`define IO_BASE_DMA_MASTER 16'h00C0
`define IO_MW_DMA_MASTER   5
`define IO_BASE_DMA_PAGE   16'h0080
`define IO_MW_DMA_PAGE     4
`define IO_BASE_DMA_SLAVE  16'h0000
`define IO_MW_DMA_SLAVE    4

`define IO_BASE_PIC_MASTER 16'h0020
`define IO_BASE_PIC_SLAVE  16'h00A0
`define IO_MW_PIC          1

`define IO_BASE_PIT        16'h0040
`define IO_MW_PIT          2
`define IO_BASE_PIT_SPK    16'h0061     // speaker gate port

`define IO_BASE_PS2_IO     16'h0060
`define IO_MW_PS2_IO       3
`define IO_BASE_PS2_CTL    16'h0090
`define IO_MW_PS2_CTL      4

`define IO_BASE_RTC        16'h0070
`define IO_MW_RTC          1

`define IO_BASE_FM         16'h0388
`define IO_MW_FM           2
`define IO_BASE_SB         16'h0220
`define IO_MW_SB           4

`define IO_BASE_UART1      16'h03F8
`define IO_BASE_UART2      16'h02F8
`define IO_MW_UART         3

`define IO_BASE_MPU        16'h0330
`define IO_MW_MPU          1

`define IO_BASE_VGA_B      16'h03B0
`define IO_BASE_VGA_C      16'h03C0
`define IO_BASE_VGA_D      16'h03D0
`define IO_MW_VGA          4

`define IO_BASE_SYSCTL     16'h8888

`define SYSCFG_RESET       8'hA2
`define SYSCFG_KEY         8'hA1        // upper byte of an unlock write
`define READ_DEFAULT       8'hFF

`endif

// File: design/io_bus_pkg.sv
package io_bus_pkg;

	// bit 2 flags a 32-bit cycle
	typedef enum logic [2:0] {
		IO_SIZE_1 = 3'd1,
		IO_SIZE_2 = 3'd2,
		IO_SIZE_4 = 3'd4
	} io_size_t;

	typedef struct packed {
		logic        read;
		logic        write;
		logic [15:0] addr;
		io_size_t    size;
		logic [31:0] wdata;
	} io_cycle_t;

endpackage

// File: design/io_dev_pkg.sv
package io_dev_pkg;

	typedef struct packed {
		logic ide0;
		logic ide1;
		logic floppy;
		logic dma_master;
		logic dma_page;
		logic dma_slave;
		logic pic_master;
		logic pic_slave;
		logic pit;
		logic ps2_io;
		logic ps2_ctl;
		logic joy;
		logic rtc;
		logic fm;
		logic sb;
		logic uart1;
		logic uart2;
		logic mpu;
		logic vga_b;
		logic vga_c;
		logic vga_d;
		logic sysctl;
	} dev_sel_t;

	// read data as presented by the devices
	typedef struct packed {
		logic [31:0] ide0;
		logic [31:0] ide1;
		logic [7:0]  floppy;
		logic [7:0]  dma;
		logic [7:0]  pic;
		logic [7:0]  pit;
		logic [7:0]  ps2;
		logic [7:0]  rtc;
		logic [7:0]  sound;    // sb and fm share one byte
		logic [7:0]  uart1;
		logic [7:0]  uart2;
		logic [7:0]  mpu;
		logic [7:0]  vga;
		logic [7:0]  joy;
	} dev_rdata_t;

endpackage

// File: design/io_port_decode.sv
`timescale 1ns/10ps
`include "io_fabric_cfg.svh"

module io_port_decode
(
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  io_stb,
	input  io_bus_pkg::io_cycle_t io_cycle,

	output logic                  dec_stb,
	output io_bus_pkg::io_cycle_t dec_cycle,
	output io_dev_pkg::dev_sel_t  dec_sel
);

import io_dev_pkg::*;

dev_sel_t sel;

// true when addr and base agree above bit lsb
function automatic logic port_hit(input logic [15:0] addr, input logic [15:0] base,
                                  input int unsigned lsb);
	logic [15:0] diff;
	diff = addr ^ base;
	return (diff >> lsb) == 16'd0;
endfunction

always_comb begin
	logic [15:0] a;
	a = io_cycle.addr;
	sel.ide0       = port_hit(a, `IO_BASE_IDE0, `IO_MW_IDE0) ||
	                 port_hit(a, `IO_BASE_IDE0_ALT, `IO_MW_EXACT);
	sel.ide1       = port_hit(a, `IO_BASE_IDE1, `IO_MW_IDE1) ||
	                 port_hit(a, `IO_BASE_IDE1_ALT, `IO_MW_EXACT);
	sel.floppy     = port_hit(a, `IO_BASE_FDD_A, `IO_MW_FDD_A) ||
	                 port_hit(a, `IO_BASE_FDD_B, `IO_MW_FDD_B) ||
	                 port_hit(a, `IO_BASE_FDD_C, `IO_MW_EXACT);
	sel.dma_master = port_hit(a, `IO_BASE_DMA_MASTER, `IO_MW_DMA_MASTER);
	sel.dma_page   = port_hit(a, `IO_BASE_DMA_PAGE, `IO_MW_DMA_PAGE);
	sel.dma_slave  = port_hit(a, `IO_BASE_DMA_SLAVE, `IO_MW_DMA_SLAVE);
	sel.pic_master = port_hit(a, `IO_BASE_PIC_MASTER, `IO_MW_PIC);
	sel.pic_slave  = port_hit(a, `IO_BASE_PIC_SLAVE, `IO_MW_PIC);
	sel.pit        = port_hit(a, `IO_BASE_PIT, `IO_MW_PIT) ||
	                 port_hit(a, `IO_BASE_PIT_SPK, `IO_MW_EXACT);
	sel.ps2_io     = port_hit(a, `IO_BASE_PS2_IO, `IO_MW_PS2_IO);
	sel.ps2_ctl    = port_hit(a, `IO_BASE_PS2_CTL, `IO_MW_PS2_CTL);
	sel.joy        = port_hit(a, `IO_BASE_JOY, `IO_MW_EXACT);
	sel.rtc        = port_hit(a, `IO_BASE_RTC, `IO_MW_RTC);
	sel.fm         = port_hit(a, `IO_BASE_FM, `IO_MW_FM);
	sel.sb         = port_hit(a, `IO_BASE_SB, `IO_MW_SB);
	sel.uart1      = port_hit(a, `IO_BASE_UART1, `IO_MW_UART);
	sel.uart2      = port_hit(a, `IO_BASE_UART2, `IO_MW_UART);
	sel.mpu        = port_hit(a, `IO_BASE_MPU, `IO_MW_MPU);
	sel.vga_b      = port_hit(a, `IO_BASE_VGA_B, `IO_MW_VGA);
	sel.vga_c      = port_hit(a, `IO_BASE_VGA_C, `IO_MW_VGA);
	sel.vga_d      = port_hit(a, `IO_BASE_VGA_D, `IO_MW_VGA);
	sel.sysctl     = port_hit(a, `IO_BASE_SYSCTL, `IO_MW_EXACT);
end

// decode runs every cycle, only the strobe qualifies it
always_ff @(posedge clk_sys) begin
	if (reset) begin
		dec_stb <= 1'b0;
		dec_sel <= '0;
	end else begin
		dec_stb <= io_stb;
		dec_sel <= sel;
	end
	dec_cycle <= io_cycle;
end

endmodule

// File: design/sysctl_execute.sv
`timescale 1ns/10ps
`include "io_fabric_cfg.svh"

module sysctl_execute
(
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  dec_stb,
	input  io_bus_pkg::io_cycle_t dec_cycle,
	input  io_dev_pkg::dev_sel_t  dec_sel,

	output logic [7:0]            syscfg
);

import io_bus_pkg::*;

logic boot;       // set until the first disk access or unlock write
logic disk_hit;
logic unlock_wr;

assign disk_hit = dec_stb && (dec_sel.ide0 || dec_sel.ide1 || dec_sel.floppy);

// 16-bit write, key in the high byte, new value in the low byte
assign unlock_wr = dec_stb && dec_cycle.write && dec_sel.sysctl &&
                   (dec_cycle.size == IO_SIZE_2) &&
                   (dec_cycle.wdata[15:8] == `SYSCFG_KEY);

always_ff @(posedge clk_sys) begin
	if (reset) begin
		syscfg <= `SYSCFG_RESET;
		boot   <= 1'b1;
	end else if (disk_hit && boot) begin
		syscfg <= 8'h00;             // bios has moved on to booting
		boot   <= 1'b0;
	end else if (unlock_wr) begin
		syscfg <= dec_cycle.wdata[7:0];
		boot   <= 1'b0;
	end
end

endmodule

// File: design/io_read_result.sv
`timescale 1ns/10ps
`include "io_fabric_cfg.svh"

module io_read_result
(
	input  logic                   clk_sys,
	input  logic                   reset,

	input  logic                   dec_stb,
	input  io_bus_pkg::io_cycle_t  dec_cycle,
	input  io_dev_pkg::dev_sel_t   dec_sel,
	input  io_dev_pkg::dev_rdata_t dev_rdata,
	input  logic [15:0]            irq_in,

	output logic                   rd_stb,
	output logic [31:0]            rd_data,
	output logic                   rd_io32,
	output logic [15:0]            irq_vec
);

logic [7:0]  byte_data;
logic [31:0] word_data;
logic        io32;
logic [15:0] irq_merged;
logic        rd_hit;

// first byte device wins
always_comb begin
	if (dec_sel.floppy)                                        byte_data = dev_rdata.floppy;
	else if (dec_sel.dma_master | dec_sel.dma_slave | dec_sel.dma_page)
		byte_data = dev_rdata.dma;
	else if (dec_sel.pic_master | dec_sel.pic_slave)          byte_data = dev_rdata.pic;
	else if (dec_sel.pit)                                      byte_data = dev_rdata.pit;
	else if (dec_sel.ps2_io | dec_sel.ps2_ctl)                byte_data = dev_rdata.ps2;
	else if (dec_sel.rtc)                                      byte_data = dev_rdata.rtc;
	else if (dec_sel.sb | dec_sel.fm)                          byte_data = dev_rdata.sound;
	else if (dec_sel.uart1)                                    byte_data = dev_rdata.uart1;
	else if (dec_sel.uart2)                                    byte_data = dev_rdata.uart2;
	else if (dec_sel.mpu)                                      byte_data = dev_rdata.mpu;
	else if (dec_sel.vga_b | dec_sel.vga_c | dec_sel.vga_d)   byte_data = dev_rdata.vga;
	else if (dec_sel.joy)                                      byte_data = dev_rdata.joy;
	else                                                       byte_data = `READ_DEFAULT;
end

assign word_data = dec_sel.ide0 ? dev_rdata.ide0 :
                   dec_sel.ide1 ? dev_rdata.ide1 : {24'd0, byte_data};

// ide data port (a9 low) and sysctl take 32-bit transfers
assign io32   = ((dec_sel.ide0 | dec_sel.ide1) & ~dec_cycle.addr[9]) | dec_sel.sysctl;
assign rd_hit = dec_stb & dec_cycle.read;

always_comb begin
	irq_merged     = irq_in;
	irq_merged[9]  = irq_in[9] | irq_in[2];   // cascade line folded into 9
	irq_merged[2]  = 1'b0;
	irq_merged[11] = 1'b0;
	irq_merged[13] = 1'b0;
end

always_ff @(posedge clk_sys) begin
	if (reset) begin
		rd_stb  <= 1'b0;
		irq_vec <= 16'd0;
	end else begin
		rd_stb  <= rd_hit;
		irq_vec <= irq_merged;
	end
	if (rd_hit) begin
		rd_data <= word_data;
		rd_io32 <= io32;
	end
end

endmodule

// File: design/io_fabric_top.sv
`timescale 1ns/10ps

module io_fabric_top
(
	input  logic                   clk_sys,
	input  logic                   reset,

	input  logic                   io_stb,
	input  io_bus_pkg::io_cycle_t  io_cycle,
	input  io_dev_pkg::dev_rdata_t dev_rdata,
	input  logic [15:0]            irq_in,

	output logic [7:0]             syscfg,
	output logic                   rd_stb,
	output logic [31:0]            rd_data,
	output logic                   rd_io32,
	output logic [15:0]            irq_vec
);

import io_bus_pkg::*;
import io_dev_pkg::*;

logic      dec_stb;
io_cycle_t dec_cycle;
dev_sel_t  dec_sel;

io_port_decode decode
(
	.clk_sys   (clk_sys),
	.reset     (reset),
	.io_stb    (io_stb),
	.io_cycle  (io_cycle),
	.dec_stb   (dec_stb),
	.dec_cycle (dec_cycle),
	.dec_sel   (dec_sel)
);

sysctl_execute execute
(
	.clk_sys   (clk_sys),
	.reset     (reset),
	.dec_stb   (dec_stb),
	.dec_cycle (dec_cycle),
	.dec_sel   (dec_sel),
	.syscfg    (syscfg)
);

io_read_result result
(
	.clk_sys   (clk_sys),
	.reset     (reset),
	.dec_stb   (dec_stb),
	.dec_cycle (dec_cycle),
	.dec_sel   (dec_sel),
	.dev_rdata (dev_rdata),
	.irq_in    (irq_in),
	.rd_stb    (rd_stb),
	.rd_data   (rd_data),
	.rd_io32   (rd_io32),
	.irq_vec   (irq_vec)
);

endmodule

// File: tb/io_fabric_assertions.sv
`timescale 1ns/10ps

module io_fabric_assertions
(
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  dec_stb,
	input io_bus_pkg::io_cycle_t dec_cycle,
	input io_dev_pkg::dev_sel_t  dec_sel,
	input logic                  rd_stb
);

rd_after_read: assert property (@(posedge clk_sys) disable iff (reset)
	(dec_stb && dec_cycle.read) |=> rd_stb)
	else $error("rd_stb missing one cycle after a strobed read");

no_rd_without_read: assert property (@(posedge clk_sys) disable iff (reset)
	!(dec_stb && dec_cycle.read) |=> !rd_stb)
	else $error("rd_stb raised without a strobed read");

// the two ide channels never overlap
ide_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
	!(dec_sel.ide0 && dec_sel.ide1))
	else $error("ide0 and ide1 selected together");

rd_quiet_in_reset: assert property (@(posedge clk_sys) reset |=> !rd_stb)
	else $error("rd_stb high during reset");

endmodule

// File: tb/io_fabric_checker.sv
`timescale 1ns/10ps

module io_fabric_checker
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_stb,
	input  io_bus_pkg::io_cycle_t io_cycle,
	input  int                    test_id,
	input  logic [31:0]           exp_data,
	input  logic                  exp_io32,
	input  logic [7:0]            exp_cfg,
	input  logic [15:0]           irq_in,
	input  logic [7:0]            syscfg,
	input  logic                  rd_stb,
	input  logic [31:0]           rd_data,
	input  logic                  rd_io32,
	input  logic [15:0]           irq_vec,
	output int                    n_done,
	output int                    n_err,
	output int                    n_irq
);

typedef struct packed {
	logic        valid;
	logic        read;
	int          id;
	logic [31:0] data;
	logic        io32;
	logic [7:0]  cfg;
} pending_t;

pending_t    pipe [2];          // [0] one cycle old, [1] two cycles old
logic [15:0] irq_prev = 16'd0;
logic        rst_prev = 1'b1;
int          done_cnt = 0;
int          err_cnt = 0;
int          irq_cnt = 0;

assign n_done = done_cnt;
assign n_err  = err_cnt;
assign n_irq  = irq_cnt;

// cascade line 2 lands on 9; 2, 11 and 13 are never raised
function automatic logic [15:0] merge_irq(input logic [15:0] req);
	logic [15:0] v;
	for (int i = 0; i < 16; i++) begin
		case (i)
			2, 11, 13: v[i] = 1'b0;
			9:         v[i] = req[9] | req[2];
			default:   v[i] = req[i];
		endcase
	end
	return v;
endfunction

task automatic finish_test(input pending_t e);
	int errs;
	errs = 0;
	if (e.read && !rd_stb) begin
		$display("test %0d: no rd_stb two cycles after the read strobe (%0t)", e.id, $time);
		errs++;
	end else if (e.read) begin
		if (rd_data !== e.data) begin
			$display("ERROR %0t rd_data expected %h actual %h", $time, e.data, rd_data);
			errs++;
		end
		if (rd_io32 !== e.io32) begin
			$display("ERROR %0t rd_io32 expected %b actual %b", $time, e.io32, rd_io32);
			errs++;
		end
	end else if (rd_stb) begin
		$display("test %0d: a write produced an rd_stb pulse (%0t)", e.id, $time);
		errs++;
	end
	if (syscfg !== e.cfg) begin
		$display("ERROR %0t syscfg expected %h actual %h", $time, e.cfg, syscfg);
		errs++;
	end
	if (errs == 0)
		$display("test %0d: ok", e.id);
	else
		$display("test %0d: mismatch", e.id);
	done_cnt++;
	err_cnt += errs;
endtask

// outputs are settled half a cycle after the edge
always @(negedge clk_sys) begin
	pending_t cur;
	cur = pending_t'{io_stb & ~reset, io_cycle.read, test_id, exp_data, exp_io32, exp_cfg};
	if (!rst_prev) begin
		irq_cnt++;
		if (irq_vec !== merge_irq(irq_prev)) begin
			$display("ERROR %0t irq_vec expected %h actual %h", $time, merge_irq(irq_prev),
			         irq_vec);
			err_cnt++;
		end
		if (pipe[1].valid) begin
			finish_test(pipe[1]);
		end else if (rd_stb) begin
			$display("rd_stb pulsed at %0t with no read strobe two cycles earlier", $time);
			err_cnt++;
		end
	end
	pipe[1]  = pipe[0];
	pipe[0]  = cur;
	irq_prev = irq_in;
	rst_prev = reset;
end

endmodule

// File: tb/io_fabric_tb.sv
`timescale 1ns/10ps

module io_fabric_tb;

import io_bus_pkg::*;
import io_dev_pkg::*;

typedef struct packed {
	logic        rd;
	logic [15:0] addr;
	io_size_t    size;
	logic [31:0] wdata;
	logic [31:0] exp_data;
	logic        exp_io32;
	logic [7:0]  exp_cfg;
	logic [1:0]  gap;        // idle cycles after the strobe
} entry_t;

logic        clk_sys = 1'b0;
logic        reset;
logic        io_stb;
io_cycle_t   io_cycle;
dev_rdata_t  dev_rdata;
logic [15:0] irq_in;
logic [7:0]  syscfg;
logic        rd_stb;
logic [31:0] rd_data;
logic        rd_io32;
logic [15:0] irq_vec;
int          test_id;
logic [31:0] exp_data;
logic        exp_io32;
logic [7:0]  exp_cfg;
int          n_done;
int          n_err;
int          n_irq;
int          timeout_cycles = 0;
integer      seed = 23459;
entry_t      tbl[$];

always #50 clk_sys = ~clk_sys;

io_fabric_top UUT
(
	.clk_sys (clk_sys), .reset (reset), .io_stb (io_stb), .io_cycle (io_cycle),
	.dev_rdata (dev_rdata), .irq_in (irq_in), .syscfg (syscfg), .rd_stb (rd_stb),
	.rd_data (rd_data), .rd_io32 (rd_io32), .irq_vec (irq_vec)
);

io_fabric_checker compare
(
	.clk_sys (clk_sys), .reset (reset), .io_stb (io_stb), .io_cycle (io_cycle),
	.test_id (test_id), .exp_data (exp_data), .exp_io32 (exp_io32), .exp_cfg (exp_cfg),
	.irq_in (irq_in), .syscfg (syscfg), .rd_stb (rd_stb), .rd_data (rd_data),
	.rd_io32 (rd_io32), .irq_vec (irq_vec), .n_done (n_done), .n_err (n_err), .n_irq (n_irq)
);

bind io_read_result io_fabric_assertions timing_checks
(
	.clk_sys (clk_sys), .reset (reset), .dec_stb (dec_stb), .dec_cycle (dec_cycle),
	.dec_sel (dec_sel), .rd_stb (rd_stb)
);

task automatic add_entry(input logic rd, input logic [15:0] addr, input io_size_t size,
                         input logic [31:0] wdata, input logic [31:0] data,
                         input logic io32, input logic [7:0] cfg, input logic [1:0] gap);
	tbl.push_back(entry_t'{rd, addr, size, wdata, data, io32, cfg, gap});
endtask

task automatic drive_entry(input int idx);
	io_stb         = 1'b1;
	io_cycle.read  = tbl[idx].rd;
	io_cycle.write = ~tbl[idx].rd;
	io_cycle.addr  = tbl[idx].addr;
	io_cycle.size  = tbl[idx].size;
	io_cycle.wdata = tbl[idx].wdata;
	test_id        = idx;
	exp_data       = tbl[idx].exp_data;
	exp_io32       = tbl[idx].exp_io32;
	exp_cfg        = tbl[idx].exp_cfg;
endtask

always @(posedge clk_sys) begin
	integer rnd;
	#1;
	rnd    = $random(seed);
	irq_in = rnd[15:0];
end

initial begin
	wait (timeout_cycles != 0);
	repeat (timeout_cycles) @(posedge clk_sys);
	$display("timeout: only %0d of %0d tests finished", n_done, tbl.size());
	$display("test failed");
	$finish;
end

initial begin
	reset     = 1'b1;
	io_stb    = 1'b0;
	io_cycle  = '0;
	irq_in    = 16'd0;
	test_id   = 0;
	exp_data  = '0;
	exp_io32  = 1'b0;
	exp_cfg   = '0;
	dev_rdata = '{32'h0D0C_0B0A, 32'h1A1B_1C1D, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55,
	              8'h66, 8'h77, 8'h88, 8'h99, 8'hAA, 8'hBB, 8'hCC};

	// byte devices back to back; 0061 is both pit and ps2, pit wins
	add_entry(1'b1, 16'h0061, IO_SIZE_1, '0, 32'h44, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0020, IO_SIZE_1, '0, 32'h33, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h00C5, IO_SIZE_1, '0, 32'h22, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0087, IO_SIZE_1, '0, 32'h22, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0092, IO_SIZE_1, '0, 32'h55, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0071, IO_SIZE_1, '0, 32'h66, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0389, IO_SIZE_1, '0, 32'h77, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h03FD, IO_SIZE_1, '0, 32'h88, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h02F8, IO_SIZE_1, '0, 32'h99, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0331, IO_SIZE_1, '0, 32'hAA, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h03DA, IO_SIZE_1, '0, 32'hBB, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0201, IO_SIZE_1, '0, 32'hCC, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0008, IO_SIZE_1, '0, 32'h22, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h00A1, IO_SIZE_1, '0, 32'h33, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0064, IO_SIZE_1, '0, 32'h55, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h022F, IO_SIZE_1, '0, 32'h77, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h03B4, IO_SIZE_1, '0, 32'hBB, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h03C5, IO_SIZE_1, '0, 32'hBB, 1'b0, 8'hA2, 2'd0);
	add_entry(1'b1, 16'h0300, IO_SIZE_1, '0, 32'hFF, 1'b0, 8'hA2, 2'd2);
	add_entry(1'b1, 16'h8888, IO_SIZE_4, '0, 32'hFF, 1'b1, 8'hA2, 2'd2);
	add_entry(1'b0, 16'h8888, IO_SIZE_2, 32'hB25C, '0, 1'b0, 8'hA2, 2'd2);
	add_entry(1'b0, 16'h8888, IO_SIZE_1, 32'hA15C, '0, 1'b0, 8'hA2, 2'd2);
	// first disk access leaves the boot state
	add_entry(1'b1, 16'h03F2, IO_SIZE_1, '0, 32'h11, 1'b0, 8'h00, 2'd2);
	add_entry(1'b1, 16'h01F0, IO_SIZE_4, '0, 32'h0D0C_0B0A, 1'b1, 8'h00, 2'd2);
	add_entry(1'b1, 16'h03F6, IO_SIZE_1, '0, 32'h0D0C_0B0A, 1'b0, 8'h00, 2'd2);
	add_entry(1'b1, 16'h0170, IO_SIZE_4, '0, 32'h1A1B_1C1D, 1'b1, 8'h00, 2'd2);
	add_entry(1'b0, 16'h8888, IO_SIZE_2, 32'hA15C, '0, 1'b0, 8'h5C, 2'd2);
	add_entry(1'b0, 16'h8888, IO_SIZE_2, 32'hA033, '0, 1'b0, 8'h5C, 2'd2);
	add_entry(1'b0, 16'h8888, IO_SIZE_1, 32'hA177, '0, 1'b0, 8'h5C, 2'd2);
	add_entry(1'b1, 16'h0376, IO_SIZE_1, '0, 32'h1A1B_1C1D, 1'b0, 8'h5C, 2'd2);
	timeout_cycles = tbl.size() * 4 + 16;

	repeat (16) @(posedge clk_sys);
	#1;
	reset = 1'b0;
	foreach (tbl[i]) begin
		drive_entry(i);
		@(posedge clk_sys);
		#1;
		io_stb         = 1'b0;
		io_cycle.read  = 1'b0;
		io_cycle.write = 1'b0;
		repeat (tbl[i].gap) begin
			@(posedge clk_sys);
			#1;
		end
	end

	wait (n_done == tbl.size());
	repeat (2) @(posedge clk_sys);
	$display("tests %0d, irq checks %0d, errors %0d", n_done, n_irq, n_err);
	if (n_err == 0)
		$display("test passed");
	else
		$display("test failed");
	$finish;
end

endmodule

// File: project.f
+incdir+design
design/io_bus_pkg.sv
design/io_dev_pkg.sv
design/io_port_decode.sv
design/sysctl_execute.sv
design/io_read_result.sv
design/io_fabric_top.sv
tb/io_fabric_assertions.sv
tb/io_fabric_checker.sv
tb/io_fabric_tb.sv

// File: Makefile
TOP = io_fabric_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

obj_dir/V$(TOP): project.f design/*.sv design/*.svh tb/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
